// File: Makefile
# Verilator build and run for the receive deserializer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := serdes_rx_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(SIM_LOG)
	grep -q "^TESTBENCH PASSED$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: verif/serdes_rx_tb.sv
// Testbench for the receive deserializer
// Clock, reset, training, data and enable-gating stimulus
// Word boundary reference model, comparing process and watchdog

`timescale 1ns/1ps
`default_nettype none

module serdes_rx_tb import serdes_rx_pkg::*; ();

    localparam int DATA_WORDS = 40;
    localparam int OFF_WORDS  = 3;                   // Words sent with enable_n high
    localparam int TAIL_WORDS = 2;
    localparam int TRAIN_BITS = (3 * WIDTH + LOCK_RUN) * WIDTH;  // Alignment and lock budget
    localparam int MAX_BITS   =
        TRAIN_BITS + (DATA_WORDS + OFF_WORDS + TAIL_WORDS) * WIDTH;
    localparam int TIMEOUT_NS = (MAX_BITS + TRAIN_BITS + 2 * SETTLE_MAX + 100) * 40;

    logic             clkGHz_clkbuf;
    logic             reset_buf_n;
    logic             enable_n;
    logic             data_i;
    logic             bitslip_ctrl_n;
    logic [WIDTH-1:0] data_o;
    logic             data_valid;
    logic             ready;

    bit rx_bit[$];                                   // Bit the deserializer shifts per position
    bit rx_slip[$];                                  // Slip pulse at that position
    int offset;                                      // Phase of the training stream
    int next_word    = 0;                            // First word not yet judged by the model
    int train_run    = 0;
    bit slip_req     = 1'b0;
    bit model_locked = 1'b0;
    int first_data   = 0;
    int first_off    = 32'h7fff_ffff;
    int chk_idx      = 0;                            // Next word the comparator expects
    bit in_data      = 1'b0;
    bit ready_seen   = 1'b0;
    int cycles       = 0;                            // Edges since reset release

    serdes_rx_top dut0 (.*);

    initial begin
        clkGHz_clkbuf = 1'b0;
        forever #20 clkGHz_clkbuf = ~clkGHz_clkbuf;
    end

    //**************************************************
    // Reference model
    //**************************************************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // Position of the last bit of word n, -1 while not recorded yet.
    // Slip positions are shifted in but not counted.
    function automatic int word_end(input int n);
        int counted;
        counted = 0;
        for (int p = 0; p < rx_bit.size(); p++) begin
            if (!rx_slip[p]) begin
                counted++;
                if (counted == WIDTH * (n + 1)) begin
                    return p;
                end
            end
        end
        return -1;
    endfunction

    function automatic logic [WIDTH-1:0] expected_word(input int n);
        logic [WIDTH-1:0] w;
        int               last;
        last = word_end(n);
        w    = '0;
        for (int i = 0; i < WIDTH; i++) begin
            w = {w[WIDTH-2:0], rx_bit[last - WIDTH + 1 + i]};  // Oldest bit ends in MSB
        end
        return w;
    endfunction

    //**************************************************
    // Stimulus helpers
    //**************************************************

    task automatic drive_bit(input bit b, input bit off, input bit slip);
        logic [WIDTH-1:0] w;
        @(posedge clkGHz_clkbuf);
        data_i         <= b;
        enable_n       <= off;
        bitslip_ctrl_n <= !slip;
        rx_bit.push_back(off ? 1'b0 : b);            // Disabled input reads 0
        rx_slip.push_back(slip);                     // Slip lands with this bit
        while (word_end(next_word) >= 0) begin
            w = expected_word(next_word);
            next_word++;
            if (w == TRAIN_WORD) begin
                train_run++;
                if (train_run >= LOCK_RUN) begin
                    model_locked = 1'b1;
                end
            end else begin
                train_run = 0;
                slip_req  = 1'b1;                    // Mismatch asks for one bitslip
            end
        end
    endtask

    task automatic send_train_bit();
        bit slip;
        slip     = slip_req;
        slip_req = 1'b0;
        drive_bit(TRAIN_WORD[WIDTH - 1 - (rx_bit.size() + offset) % WIDTH], 1'b0, slip);
    endtask

    task automatic send_word(input logic [WIDTH-1:0] w, input bit off);
        for (int i = WIDTH - 1; i >= 0; i--) begin
            drive_bit(w[i], off, 1'b0);
        end
    endtask

    function automatic logic [WIDTH-1:0] random_word();
        logic [WIDTH-1:0] w;
        do begin
            w = WIDTH'($urandom_range((1 << WIDTH) - 1, 0));
        end while (w == TRAIN_WORD);                 // Never equal to the training word
        return w;
    endfunction

    task automatic check_reset_state(input string when);
        assert (!ready && !data_valid && data_o == '0)
            else fail_run($sformatf(
                "error reset_state %s: expected ready 0 valid 0 data %h, actual %b %b %h",
                when, {WIDTH{1'b0}}, ready, data_valid, data_o));
    endtask

    // Three edges of reset, model back to its reset view
    task automatic reset_dut();
        reset_buf_n    <= 1'b0;
        enable_n       <= 1'b0;
        data_i         <= 1'b0;
        bitslip_ctrl_n <= 1'b1;
        rx_bit       = '{1'b0, 1'b0};                // Front reset value, then idle input
        rx_slip      = '{1'b0, 1'b0};
        next_word    = 0;
        train_run    = 0;
        slip_req     = 1'b0;
        model_locked = 1'b0;
        ready_seen   = 1'b0;
        repeat (2) @(posedge clkGHz_clkbuf);
        @(negedge clkGHz_clkbuf);
        check_reset_state("during reset");
        @(posedge clkGHz_clkbuf);
        reset_buf_n <= 1'b1;
        @(negedge clkGHz_clkbuf);
        check_reset_state("after release");
    endtask

    //**************************************************
    // Comparing process
    //**************************************************

    task automatic compare_word();
        logic [WIDTH-1:0] exp;
        string            name;
        if (!in_data && data_o == TRAIN_WORD) begin
            return;                                  // Training still draining after ready
        end
        if (!in_data) begin
            in_data = 1'b1;
            chk_idx = first_data;
        end
        name = (chk_idx >= first_off && chk_idx < first_off + OFF_WORDS) ?
               "enable_gating" : "data_capture";
        assert (word_end(chk_idx) >= 0)
            else fail_run("data_valid reported a word whose bits were never driven");
        exp = expected_word(chk_idx);
        assert (data_o == exp)
            else fail_run($sformatf("error %s word %0d: expected %h, actual %h",
                                    name, chk_idx, exp, data_o));
        chk_idx++;
    endtask

    always @(posedge clkGHz_clkbuf) begin
        if (!reset_buf_n) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    always @(negedge clkGHz_clkbuf) begin
        if (reset_buf_n) begin
            if (ready && !ready_seen) begin
                assert (cycles >= SETTLE_MAX)
                    else fail_run($sformatf("error settle_gate: expected cycle >= %0d, actual %0d",
                                            SETTLE_MAX, cycles));
                assert (model_locked)
                    else fail_run("ready rose before a full run of aligned training words");
                ready_seen = 1'b1;
            end
            assert (ready || !ready_seen) else fail_run("ready fell although lock is sticky");
            if (data_valid) begin
                compare_word();
            end
        end
    end

    //**************************************************
    // Test sequence and watchdog
    //**************************************************

    initial begin
        int idle;
        void'($urandom(32'hb436fd49));
        offset = int'($urandom_range(WIDTH - 1, 1));
        reset_dut();
        while (cycles < SETTLE_MAX) begin            // Late training, lock gates ready
            drive_bit(1'b0, 1'b0, 1'b0);
        end
        while (!ready_seen) begin
            send_train_bit();
            assert (rx_bit.size() < SETTLE_MAX + TRAIN_BITS)
                else fail_run("ready never rose after the late training stream");
        end
        reset_dut();
        while (!ready_seen) begin                    // Alignment, lock and settle gate
            send_train_bit();
            assert (rx_bit.size() < MAX_BITS)
                else fail_run("ready never rose after training and settling");
        end
        while ((rx_bit.size() + offset) % WIDTH != 0) begin
            send_train_bit();
        end
        first_data = next_word;
        for (int i = 0; i < DATA_WORDS; i++) begin
            send_word(random_word(), 1'b0);
        end
        first_off = next_word;
        for (int i = 0; i < OFF_WORDS; i++) begin
            send_word(random_word(), 1'b1);
        end
        for (int i = 0; i < TAIL_WORDS; i++) begin
            send_word(random_word(), 1'b0);
        end
        idle = 0;
        while (chk_idx < first_off + OFF_WORDS + TAIL_WORDS && idle < 4 * WIDTH) begin
            drive_bit(1'b0, 1'b0, 1'b0);             // Flush the pipeline
            idle++;
        end
        if (in_data && chk_idx >= first_off + OFF_WORDS + TAIL_WORDS) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("words missing at the output after the last word was sent");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("watchdog expired before the tests finished");
    end

endmodule : serdes_rx_tb

`default_nettype wire

// File: verilog/align_lock.sv
// Alignment lock detector
// Counts consecutive training-word matches, sticky lock at LOCK_RUN
// Forwards each word one cycle later alongside the lock level

`timescale 1ns/1ps
`default_nettype none

module align_lock import serdes_rx_pkg::*; (
    input  logic       clkGHz_clkbuf,
    input  logic       reset_buf_n,
    input  word_t      word_i,
    output lock_word_t lock_o
);

    logic [RUN_W-1:0] run_cnt;        // Consecutive matches so far
    logic             locked_q;
    logic             valid_q;
    logic [WIDTH-1:0] data_q;
    logic             is_train;
    logic             run_full;

    assign is_train = (word_i.data == TRAIN_WORD);
    assign run_full = (run_cnt == RUN_W'(LOCK_RUN));

    //**************************************************
    // Match counter and lock
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            run_cnt  <= '0;
            locked_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= word_i.valid;
            if (word_i.valid) begin
                if (!is_train) begin
                    run_cnt <= '0;                  // Run broken
                end else if (!run_full) begin
                    run_cnt <= run_cnt + 1'b1;      // Saturates at LOCK_RUN
                end
                // Rises together with the word that completes the run
                if (is_train && run_cnt == RUN_W'(LOCK_RUN - 1)) begin
                    locked_q <= 1'b1;
                end
            end
        end
    end

    // Forwarded payload
    always_ff @(posedge clkGHz_clkbuf) begin
        data_q <= word_i.data;
    end

    assign lock_o = '{word: '{data: data_q, valid: valid_q}, locked: locked_q};

    // No loss of lock in this design
    lock_sticky_a : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        lock_o.locked |=> lock_o.locked
    ) else $error("lock dropped without reset");

endmodule : align_lock

`default_nettype wire

// File: verilog/serdes_rx_pkg.sv
// Shared definitions for the receive deserializer
// Word width, training pattern, lock run length, settle count
// Stage-to-stage packed structs

`default_nettype none

package serdes_rx_pkg;

    //**************************************************
    // Sizes and constants
    //**************************************************

    localparam int WIDTH = 10;                       // Deserialization width
    localparam int CNT_W = $clog2(WIDTH);            // Bit counter width

    // Half ones then half zeros, first received bit in the MSB
    localparam logic [WIDTH-1:0] TRAIN_WORD = {
        {(WIDTH / 2){1'b1}},
        {(WIDTH - WIDTH / 2){1'b0}}
    };

    localparam int LOCK_RUN = 4;                     // Aligned words needed for lock
    localparam int RUN_W    = $clog2(LOCK_RUN + 1);  // Match counter width

    localparam int SETTLE_W   = 8;                   // Settle counter width
    localparam int SETTLE_MAX = 255;                 // Settle counter saturation

    //**************************************************
    // Stage structs
    //**************************************************

    // serial_front to word_deser
    typedef struct packed {
        logic ser_bit;                               // Gated serial bit
        logic slip;                                  // One-cycle bitslip pulse
    } bit_t;

    // word_deser to align_lock, and align_lock to word_output
    typedef struct packed {
        logic [WIDTH-1:0] data;                      // Received word
        logic             valid;                     // One-cycle strobe
    } word_t;

    // align_lock to word_output
    typedef struct packed {
        word_t word;                                 // Forwarded word
        logic  locked;                               // Sticky lock level
    } lock_word_t;

endpackage : serdes_rx_pkg

`default_nettype wire

// File: verilog/serdes_rx_top.sv
// Receive deserializer top level
// serial_front -> word_deser -> align_lock -> word_output

`timescale 1ns/1ps
`default_nettype none

module serdes_rx_top import serdes_rx_pkg::*; (
    input  logic             clkGHz_clkbuf,  // Bit clock
    input  logic             reset_buf_n,
    input  logic             enable_n,
    input  logic             data_i,
    input  logic             bitslip_ctrl_n,
    output logic [WIDTH-1:0] data_o,
    output logic             data_valid,
    output logic             ready
);

    bit_t       bit_s;
    word_t      word_s;
    lock_word_t lock_s;

    serial_front front0 (
        .clkGHz_clkbuf  (clkGHz_clkbuf),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .bit_o          (bit_s)
    );

    word_deser deser0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .bit_i         (bit_s),
        .word_o        (word_s)
    );

    align_lock align0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word_i        (word_s),
        .lock_o        (lock_s)
    );

    word_output out0 (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .lock_i        (lock_s),
        .data_o        (data_o),
        .data_valid    (data_valid),
        .ready         (ready)
    );

endmodule : serdes_rx_top

`default_nettype wire

// File: verilog/serial_front.sv
// Serial input stage
// Registers the serial bit with active-low enable gating
// Turns the active-low bitslip level into a single pulse

`timescale 1ns/1ps
`default_nettype none

module serial_front import serdes_rx_pkg::*; (
    input  logic clkGHz_clkbuf,
    input  logic reset_buf_n,
    input  logic enable_n,       // Low to enable
    input  logic data_i,
    input  logic bitslip_ctrl_n, // Low to request a bitslip
    output bit_t bit_o
);

    logic ser_bit_q;
    logic slip_q;
    logic slip_n_prev;           // Previous bitslip sample

    //**************************************************
    // Bit and bitslip registers
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            ser_bit_q   <= 1'b0;
            slip_q      <= 1'b0;
            slip_n_prev <= 1'b1;                           // Idle level is high
        end else begin
            ser_bit_q   <= enable_n ? 1'b0 : data_i;       // Disabled input reads 0
            slip_q      <= slip_n_prev & ~bitslip_ctrl_n;  // Falling edge of request
            slip_n_prev <= bitslip_ctrl_n;
        end
    end

    assign bit_o = '{ser_bit: ser_bit_q, slip: slip_q};

    //**************************************************
    // Checks
    //**************************************************

    // One request gives one pulse, whatever the level does
    slip_single_pulse_a : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        bit_o.slip |=> !bit_o.slip
    ) else $error("slip pulse lasted more than one cycle");

endmodule : serial_front

`default_nettype wire

// File: verilog/word_deser.sv
// Word deserializer
// WIDTH-bit shift register, bit counter and word strobe
// A slip pulse stalls the counter and moves the boundary one bit later

`timescale 1ns/1ps
`default_nettype none

module word_deser import serdes_rx_pkg::*; (
    input  logic  clkGHz_clkbuf,
    input  logic  reset_buf_n,
    input  bit_t  bit_i,
    output word_t word_o
);

    logic [CNT_W-1:0] bit_cnt;        // Position within the current word
    logic             valid_q;
    logic [WIDTH-2:0] shift_q;        // Previous WIDTH-1 bits
    logic [WIDTH-1:0] data_q;
    logic             word_done;
    logic [WIDTH-1:0] shift_next;

    // Incoming bit enters at the LSB, so the oldest bit ends in the MSB
    assign shift_next = {shift_q, bit_i.ser_bit};

    // Slip cycles never close a word
    assign word_done = !bit_i.slip && (bit_cnt == CNT_W'(WIDTH - 1));

    //**************************************************
    // Counter and strobe
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_done;
            if (bit_i.slip) begin
                bit_cnt <= bit_cnt;             // Hold, boundary shifts by one
            end else if (word_done) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    //**************************************************
    // Shift register and word capture
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf) begin
        shift_q <= shift_next[WIDTH-2:0];       // Shifts on slip cycles too
        if (word_done) begin
            data_q <= shift_next;
        end
    end

    assign word_o = '{data: data_q, valid: valid_q};

    counter_range_a : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        bit_cnt < CNT_W'(WIDTH)
    ) else $error("bit counter left its range");

endmodule : word_deser

`default_nettype wire

// File: verilog/word_output.sv
// Output stage
// Saturating settle counter and registered ready
// Output word register loaded only while ready, with valid strobe

`timescale 1ns/1ps
`default_nettype none

module word_output import serdes_rx_pkg::*; (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  lock_word_t       lock_i,
    output logic [WIDTH-1:0] data_o,
    output logic             data_valid,
    output logic             ready
);

    logic [SETTLE_W-1:0] settle_cnt;
    logic                settled;
    logic                load;

    assign settled = (settle_cnt == SETTLE_W'(SETTLE_MAX));
    assign load    = lock_i.word.valid && ready;   // Words before ready are dropped

    //**************************************************
    // Settle counter and ready
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_cnt <= '0;
            ready      <= 1'b0;
        end else begin
            if (!settled) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
            ready <= settled && lock_i.locked;
        end
    end

    //**************************************************
    // Output word register
    //**************************************************

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o     <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= load;
            if (load) begin
                data_o <= lock_i.word.data;
            end
        end
    end

    valid_needs_ready_a : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        data_valid |-> $past(ready)
    ) else $error("data_valid without ready in the previous cycle");

endmodule : word_output

`default_nettype wire

// File: vlog.f
verilog/serdes_rx_pkg.sv
verilog/serial_front.sv
verilog/word_deser.sv
verilog/align_lock.sv
verilog/word_output.sv
verilog/serdes_rx_top.sv
verif/serdes_rx_tb.sv
